// ==== hw/freq_pkg.sv ====
package freq_pkg;

    // the MAX7219 drives eight digits
    localparam int num_digits = 8;

    // latched measurement, digit 0 in bits [3:0]
    typedef logic [num_digits-1:0][3:0] bcd_code_t;

    typedef enum logic [7:0] {
        REG_DIGIT0     = 8'h01,
        REG_DIGIT1     = 8'h02,
        REG_DIGIT2     = 8'h03,
        REG_DIGIT3     = 8'h04,
        REG_DIGIT4     = 8'h05,
        REG_DIGIT5     = 8'h06,
        REG_DIGIT6     = 8'h07,
        REG_DIGIT7     = 8'h08,
        REG_DECODE     = 8'h09,
        REG_INTENSITY  = 8'h0a,
        REG_SCAN_LIMIT = 8'h0b,
        REG_SHUTDOWN   = 8'h0c
    } max_reg_t;

    // address goes out first, msb first
    typedef struct packed {
        max_reg_t   addr;
        logic [7:0] data;
    } max_word_t;

    typedef enum logic [1:0] {
        SEQ_SETUP,
        SEQ_IDLE,
        SEQ_DIGITS
    } seq_state_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_SHIFT,
        SER_LOAD
    } ser_state_t;

endpackage

// ==== hw/gate_timer.sv ====
`timescale 1ns/1ps

module gate_timer #(
    parameter logic [27:0] gate_cycles = 28'd25000000
) (
    input  logic clk,
    input  logic main_reset,
    input  logic sig_in,
    output logic count_pulse,
    output logic gate_end
);

    localparam logic [27:0] gate_last = gate_cycles - 28'd1;

    logic [1:0]  sync_q;
    logic        edge_q;
    logic [27:0] gate_cnt;

    // two-flop synchronizer plus edge register
    always_ff @(posedge clk) begin
        if (main_reset) begin
            sync_q <= 2'b00;
            edge_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], sig_in};
            edge_q <= sync_q[1];
        end
    end

    assign count_pulse = sync_q[1] & ~edge_q; // rising edge only

    // window down-counter, reloads on the last cycle
    always_ff @(posedge clk) begin
        if (main_reset) begin
            gate_cnt <= gate_last;
        end else if (gate_cnt == 28'd0) begin
            gate_cnt <= gate_last;
        end else begin
            gate_cnt <= gate_cnt - 28'd1;
        end
    end

    assign gate_end = (gate_cnt == 28'd0);

    // windows are never shorter than two cycles
    gate_end_single_cycle: assert property (
        @(posedge clk) disable iff (main_reset)
        gate_end |=> !gate_end
    );

endmodule

// ==== hw/decade_digit.sv ====
`timescale 1ns/1ps

module decade_digit (
    input  logic       clk,
    input  logic       main_reset,
    input  logic       carry_in,
    input  logic       gate_end,
    output logic       carry_out,
    output logic [3:0] digit
);

    logic [3:0] cnt_q;
    logic [3:0] cnt_inc;
    logic       at_nine;

    assign at_nine   = (cnt_q == 4'd9);
    assign carry_out = carry_in & at_nine; // ripples to the next decade

    always_comb begin
        cnt_inc = cnt_q;
        if (carry_in) begin
            cnt_inc = at_nine ? 4'd0 : cnt_q + 4'd1;
        end
    end

    // running value, restarts at each window
    always_ff @(posedge clk) begin
        if (main_reset) begin
            cnt_q <= 4'd0;
        end else if (gate_end) begin
            cnt_q <= 4'd0;
        end else begin
            cnt_q <= cnt_inc;
        end
    end

    // result holds for a whole window
    always_ff @(posedge clk) begin
        if (gate_end) begin
            digit <= cnt_inc; // includes this cycle's count
        end
    end

    bcd_in_range: assert property (
        @(posedge clk) disable iff (main_reset)
        cnt_q <= 4'd9
    );

endmodule

// ==== hw/max7219_serializer.sv ====
`timescale 1ns/1ps

module max7219_serializer #(
    parameter int clk_div = 8
) (
    input  logic                clk,
    input  logic                main_reset,
    input  logic                set,
    input  freq_pkg::max_word_t word,
    output logic                busy,
    output logic                clko,
    output logic                dout,
    output logic                load
);

    localparam int div_w = $clog2(2 * clk_div);
    localparam logic [div_w-1:0] div_last = div_w'(2 * clk_div - 1);
    localparam logic [div_w-1:0] div_half = div_w'(clk_div);

    freq_pkg::ser_state_t state;
    logic [div_w-1:0]     div_cnt;
    logic [3:0]           bit_cnt;
    logic [15:0]          shreg;
    logic                 div_wrap;

    assign div_wrap = (div_cnt == div_last); // end of one bit period

    always_ff @(posedge clk) begin
        if (main_reset) begin
            state   <= freq_pkg::SER_IDLE;
            div_cnt <= '0;
            bit_cnt <= 4'd0;
        end else begin
            case (state)
                freq_pkg::SER_IDLE: begin
                    div_cnt <= '0;
                    bit_cnt <= 4'd0;
                    if (set) begin
                        state <= freq_pkg::SER_SHIFT;
                    end
                end
                freq_pkg::SER_SHIFT: begin
                    if (div_wrap) begin
                        div_cnt <= '0;
                        if (bit_cnt == 4'd15) begin
                            state <= freq_pkg::SER_LOAD;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end else begin
                        div_cnt <= div_cnt + div_w'(1);
                    end
                end
                freq_pkg::SER_LOAD: begin
                    if (div_wrap) begin
                        div_cnt <= '0;
                        state   <= freq_pkg::SER_IDLE;
                    end else begin
                        div_cnt <= div_cnt + div_w'(1);
                    end
                end
                default: state <= freq_pkg::SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == freq_pkg::SER_IDLE && set) begin
            shreg <= word;
        end else if (state == freq_pkg::SER_SHIFT && div_wrap) begin
            shreg <= {shreg[14:0], 1'b0}; // msb first
        end
    end

    assign busy = (state != freq_pkg::SER_IDLE);
    assign clko = (state == freq_pkg::SER_SHIFT) && (div_cnt >= div_half); // mid-bit rise
    assign dout = (state == freq_pkg::SER_SHIFT) && shreg[15];
    assign load = (state == freq_pkg::SER_LOAD);

    // the sequencer must wait for the previous word
    no_set_while_busy: assert property (
        @(posedge clk) disable iff (main_reset)
        busy |-> !set
    );

endmodule

// ==== hw/display_sequencer.sv ====
`timescale 1ns/1ps

module display_sequencer (
    input  logic                clk,
    input  logic                main_reset,
    input  freq_pkg::bcd_code_t result,
    input  logic                result_valid,
    input  logic                busy,
    output logic                set,
    output freq_pkg::max_word_t word
);

    localparam logic [3:0] setup_last = 4'(freq_pkg::num_digits + 3);
    localparam logic [3:0] digit_last = 4'(freq_pkg::num_digits - 1);

    freq_pkg::seq_state_t state;
    freq_pkg::bcd_code_t  burst_q;
    logic [3:0]           idx;
    logic                 pend_q;
    logic                 issue;
    logic                 start_burst;

    function automatic freq_pkg::max_word_t setup_word(input logic [3:0] i);
        freq_pkg::max_word_t w;
        if (i < 4'(freq_pkg::num_digits)) begin
            w.addr = freq_pkg::max_reg_t'(8'(i) + 8'd1);
            w.data = 8'h0f; // blank
        end else begin
            case (i)
                4'd8: begin
                    w.addr = freq_pkg::REG_DECODE;
                    w.data = 8'hff; // code B on all digits
                end
                4'd9: begin
                    w.addr = freq_pkg::REG_INTENSITY;
                    w.data = 8'h03;
                end
                4'd10: begin
                    w.addr = freq_pkg::REG_SCAN_LIMIT;
                    w.data = 8'h07; // scan all eight
                end
                default: begin
                    w.addr = freq_pkg::REG_SHUTDOWN;
                    w.data = 8'h01; // normal operation
                end
            endcase
        end
        return w;
    endfunction

    function automatic freq_pkg::max_word_t digit_word(input logic [3:0] i,
                                                       input freq_pkg::bcd_code_t code);
        freq_pkg::max_word_t w;
        logic                dp;
        dp     = (i == 4'd3) || (i == 4'd6); // decimal points
        w.addr = freq_pkg::max_reg_t'(8'(i) + 8'd1);
        w.data = {dp, 3'b000, code[i[2:0]]};
        return w;
    endfunction

    assign issue       = !busy && !set; // set lands before busy rises
    assign start_burst = (state == freq_pkg::SEQ_IDLE) && pend_q;

    always_ff @(posedge clk) begin
        if (main_reset) begin
            state  <= freq_pkg::SEQ_SETUP;
            idx    <= 4'd0;
            set    <= 1'b0;
            pend_q <= 1'b0;
        end else begin
            set    <= 1'b0;
            pend_q <= result_valid | (pend_q & ~start_burst); // newest result wins
            case (state)
                freq_pkg::SEQ_SETUP: begin
                    if (issue) begin
                        set <= 1'b1;
                        idx <= (idx == setup_last) ? 4'd0 : idx + 4'd1;
                        if (idx == setup_last) begin
                            state <= freq_pkg::SEQ_IDLE;
                        end
                    end
                end
                freq_pkg::SEQ_IDLE: begin
                    idx <= 4'd0;
                    if (pend_q) begin
                        state <= freq_pkg::SEQ_DIGITS;
                    end
                end
                freq_pkg::SEQ_DIGITS: begin
                    if (issue) begin
                        set <= 1'b1;
                        idx <= (idx == digit_last) ? 4'd0 : idx + 4'd1;
                        if (idx == digit_last) begin
                            state <= freq_pkg::SEQ_IDLE;
                        end
                    end
                end
                default: state <= freq_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_burst) begin
            burst_q <= result; // frozen for the whole burst
        end
        if (issue && state == freq_pkg::SEQ_SETUP) begin
            word <= setup_word(idx);
        end else if (issue && state == freq_pkg::SEQ_DIGITS) begin
            word <= digit_word(idx, burst_q);
        end
    end

endmodule

// ==== hw/freq_counter_max7219.sv ====
`timescale 1ns/1ps

module freq_counter_max7219 #(
    parameter logic [27:0] gate_cycles = 28'd25000000,
    parameter int          clk_div     = 8
) (
    input  logic clk,
    input  logic main_reset,
    input  logic sig_in,
    output logic clko,
    output logic dout,
    output logic load
);

    logic                        count_pulse;
    logic                        gate_end;
    logic                        result_valid;
    logic [freq_pkg::num_digits:0] carry; // top bit wraps away
    freq_pkg::bcd_code_t         result;
    freq_pkg::max_word_t         word;
    logic                        set;
    logic                        busy;

    gate_timer #(
        .gate_cycles(gate_cycles)
    ) gate_timer_inst (
        .clk        (clk),
        .main_reset (main_reset),
        .sig_in     (sig_in),
        .count_pulse(count_pulse),
        .gate_end   (gate_end)
    );

    assign carry[0] = count_pulse;

    for (genvar i = 0; i < freq_pkg::num_digits; i++) begin : g_decade
        decade_digit decade_digit_inst (
            .clk       (clk),
            .main_reset(main_reset),
            .carry_in  (carry[i]),
            .gate_end  (gate_end),
            .carry_out (carry[i+1]),
            .digit     (result[i])
        );
    end

    // digits latch on gate_end, so the result is stable one cycle later
    always_ff @(posedge clk) begin
        if (main_reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= gate_end;
        end
    end

    display_sequencer display_sequencer_inst (
        .clk         (clk),
        .main_reset  (main_reset),
        .result      (result),
        .result_valid(result_valid),
        .busy        (busy),
        .set         (set),
        .word        (word)
    );

    max7219_serializer #(
        .clk_div(clk_div)
    ) max7219_serializer_inst (
        .clk       (clk),
        .main_reset(main_reset),
        .set       (set),
        .word      (word),
        .busy      (busy),
        .clko      (clko),
        .dout      (dout),
        .load      (load)
    );

endmodule

// ==== sim/tb_freq_counter_max7219.sv ====
`timescale 1ns/1ps

module tb_freq_counter_max7219;

    localparam logic [27:0] gate_cycles  = 28'd4000;
    localparam int          clk_div      = 2;
    localparam int          num_bursts   = 10;
    localparam int          word_timeout = 6000; // longer than one gate

    logic        clk;
    logic        main_reset;
    logic        sig_in;
    logic        clko;
    logic        dout;
    logic        load;

    logic        wave_on;
    int          cur_period;
    logic [15:0] lfsr;

    logic [15:0] word_q[$];
    logic [15:0] rx_shift;
    int          clko_rises;
    logic        clko_prev;
    logic        load_prev;

    freq_counter_max7219 #(
        .gate_cycles(gate_cycles),
        .clk_div    (clk_div)
    ) freq_counter_max7219_inst (
        .clk       (clk),
        .main_reset(main_reset),
        .sig_in    (sig_in),
        .clko      (clko),
        .dout      (dout),
        .load      (load)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // six bits give 4 to 67 cycles
    task automatic draw_period(output int period);
        logic [5:0] bits;
        bits = '0;
        for (int b = 0; b < 6; b++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[4:0], lfsr[0]};
        end
        period = int'(bits) + 4;
    endtask

    function automatic logic [15:0] setup_entry(input int i);
        logic [15:0] e;
        case (i)
            8:       e = 16'h09ff; // decode all digits
            9:       e = 16'h0a03;
            10:      e = 16'h0b07;
            11:      e = 16'h0c01; // leave shutdown
            default: e = {8'(i + 1), 8'h0f}; // blank digit
        endcase
        return e;
    endfunction

    // square wave, high for the first half of each period
    initial begin
        int phase;
        phase = 0;
        sig_in <= 1'b0;
        forever begin
            @(posedge clk);
            if (wave_on) begin
                sig_in <= (phase < cur_period / 2);
                phase = (phase >= cur_period - 1) ? 0 : phase + 1;
            end else begin
                sig_in <= 1'b0;
                phase = 0;
            end
        end
    end

    // serial bus monitor
    always @(posedge clk) begin
        if (main_reset) begin
            clko_prev  <= 1'b0;
            load_prev  <= 1'b0;
            clko_rises <= 0;
            rx_shift   <= 16'h0000;
        end else begin
            clko_prev <= clko;
            load_prev <= load;
            if (clko && !clko_prev) begin
                rx_shift   <= {rx_shift[14:0], dout};
                clko_rises <= clko_rises + 1;
            end
            if (load && !load_prev) begin
                check_value("clko rises per word", 32'(clko_rises), 32'd16);
                word_q.push_back(rx_shift);
                clko_rises <= 0;
            end
        end
    end

    task automatic next_word(output logic [15:0] w);
        int waited;
        waited = 0;
        while (word_q.size() == 0) begin
            if (waited >= word_timeout) begin
                stop_on_error($sformatf("Timeout: no MAX7219 word within %0d cycles",
                                        word_timeout));
            end
            @(posedge clk);
            waited++;
        end
        w = word_q.pop_front();
    endtask

    task automatic check_setup();
        logic [15:0] w;
        logic [15:0] e;
        for (int i = 0; i < 12; i++) begin
            next_word(w);
            e = setup_entry(i);
            check_value($sformatf("setup word %0d addr", i), 32'(w[15:8]), 32'(e[15:8]));
            check_value($sformatf("setup word %0d data", i), 32'(w[7:0]), 32'(e[7:0]));
        end
    endtask

    task automatic receive_burst(input int burst, output int value);
        logic [15:0] w;
        int          scale;
        value = 0;
        scale = 1;
        for (int k = 0; k < freq_pkg::num_digits; k++) begin
            next_word(w);
            check_value($sformatf("burst %0d digit %0d addr", burst, k),
                        32'(w[15:8]), 32'(k + 1));
            check_value($sformatf("burst %0d digit %0d dp", burst, k),
                        32'(w[7]), (k == 3 || k == 6) ? 32'd1 : 32'd0);
            check_value($sformatf("burst %0d digit %0d data[6:4]", burst, k),
                        32'(w[6:4]), 32'd0);
            if (w[3:0] > 4'd9) begin
                stop_on_error($sformatf("Burst %0d digit %0d holds 0x%0h which is not BCD",
                                        burst, k, w[3:0]));
            end
            value += int'(w[3:0]) * scale;
            scale *= 10;
        end
    endtask

    // edges in one window lie within one of cycles / period
    task automatic check_count(input int burst, input int value, input int period);
        int span;
        span = int'(gate_cycles);
        $display("burst %0d: count %0d with period %0d", burst, value, period);
        if (value * period < span - period || value * period > span + period) begin
            stop_on_error($sformatf("Gate count %0d is not within one of %0d / %0d",
                                    value, span, period));
        end
    endtask

    initial begin
        int value;
        int period;
        main_reset <= 1'b1;
        wave_on    <= 1'b0;
        cur_period <= 4;
        lfsr = 16'd6;
        repeat (3) @(posedge clk);
        check_value("clko in reset", 32'(clko), 32'd0);
        check_value("dout in reset", 32'(dout), 32'd0);
        check_value("load in reset", 32'(load), 32'd0);
        draw_period(period);
        cur_period <= period;
        main_reset <= 1'b0;
        wave_on    <= 1'b1;
        repeat (20) begin
            @(posedge clk);
            check_value("load after reset", 32'(load), 32'd0);
        end
        check_setup();
        // period changes after odd bursts so every odd gate sees one period
        for (int burst = 1; burst <= num_bursts; burst++) begin
            receive_burst(burst, value);
            if (burst % 2 == 1) begin
                check_count(burst, value, period);
                draw_period(period);
                cur_period <= period;
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== freq_counter_max7219.f ====
hw/freq_pkg.sv
hw/gate_timer.sv
hw/decade_digit.sv
hw/max7219_serializer.sv
hw/display_sequencer.sv
hw/freq_counter_max7219.sv
sim/tb_freq_counter_max7219.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frequency meter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_freq_counter_max7219 \
    -f freq_counter_max7219.f

out="$(./obj_dir/Vtb_freq_counter_max7219 2>&1 || true)"
echo "$out"

# pass only when the testbench reports it
echo "$out" | grep -q "ALL CHECKS PASSED"
